/* rtl/exSlice.sv */
`timescale 1ns/1ps

module exSlice #(
    parameter int MUL_CYCLES = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        instrValid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] rd1,
    input  logic [31:0] rd2,
    input  logic        predTake,
    output logic        stall,
    output logic        redirect,
    output logic [31:0] redirectPc,
    output logic        resultValid,
    output logic [31:0] result,
    output logic [4:0]  writeReg
);
    logic flushE;
    logic mispredict;
    logic mulStart;
    logic timerStart;
    logic timerDone;

    idExBus decBus ();
    idExBus exBus ();

    instrDecode uDecode (
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .rd1        (rd1),
        .rd2        (rd2),
        .predTake   (predTake),
        .bus        (decBus)
    );

    idEx uIdEx (
        .clk    (clk),
        .rst    (rst),
        .stallE (stall),
        .flushE (flushE),
        .d      (decBus),
        .e      (exBus)
    );

    execStage uExec (
        .clk         (clk),
        .rst         (rst),
        .hold        (stall),                           // no write-back while MUL is timing
        .e           (exBus),
        .mispredict  (mispredict),
        .mulStart    (mulStart),
        .redirectPc  (redirectPc),
        .resultValid (resultValid),
        .result      (result),
        .writeReg    (writeReg)
    );

    mulTimer #(
        .MUL_CYCLES (MUL_CYCLES)
    ) uMulTimer (
        .clk   (clk),
        .rst   (rst),
        .start (timerStart),
        .busy  (),
        .done  (timerDone)
    );

    hazardCtrl #(
        .MUL_CYCLES (MUL_CYCLES)
    ) uHazard (
        .clk        (clk),
        .rst        (rst),
        .mispredict (mispredict),
        .mulStart   (mulStart),
        .timerDone  (timerDone),
        .stallE     (stall),
        .flushE     (flushE),
        .timerStart (timerStart),
        .redirect   (redirect)
    );

endmodule

/* rtl/execStage.sv */
`timescale 1ns/1ps

module execStage
    import pipePkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              hold,
    idExBus.snk               e,
    output logic              mispredict,
    output logic              mulStart,
    output logic [DATA_W-1:0] redirectPc,
    output logic              resultValid,
    output logic [DATA_W-1:0] result,
    output logic [REG_W-1:0]  writeReg
);
    logic [DATA_W-1:0] opB;
    logic [DATA_W-1:0] product;
    logic [DATA_W-1:0] aluOut;
    logic [DATA_W-1:0] brTarget;
    logic              taken;

    // ************************************************************************
    // ALU
    // ************************************************************************
    assign opB     = e.useImm ? e.imm : e.rd2;
    assign product = e.rd1 * opB;                       // low word only, sign does not matter

    always_comb begin
        case (e.aluOp)
            ALU_ADDU: aluOut = e.rd1 + opB;
            ALU_SUBU: aluOut = e.rd1 - opB;
            ALU_AND:  aluOut = e.rd1 & opB;
            ALU_OR:   aluOut = e.rd1 | opB;
            ALU_XOR:  aluOut = e.rd1 ^ opB;
            ALU_SLT:  aluOut = {{(DATA_W-1){1'b0}}, $signed(e.rd1) < $signed(opB)};
            ALU_SLL:  aluOut = e.rd2 << e.sa;
            ALU_LUI:  aluOut = {opB[15:0], 16'h0000};
            ALU_MUL:  aluOut = product;
            default:  aluOut = '0;
        endcase
    end

    assign mulStart = e.valid && (e.aluOp == ALU_MUL);

    // ************************************************************************
    // branch judge
    // ************************************************************************
    assign taken = ((e.brCond == BR_EQ) && (e.rd1 == e.rd2)) ||
                   ((e.brCond == BR_NE) && (e.rd1 != e.rd2));

    assign brTarget   = e.pcPlus4 + {e.imm[DATA_W-3:0], 2'b00};
    assign redirectPc = taken ? brTarget : e.pcPlus4;
    assign mispredict = e.valid && (e.brCond != BR_NONE) && (taken != e.predTake);

    // ************************************************************************
    // write-back register
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= e.valid && e.regWrite && !hold;    // a held MUL is not done yet
        end
    end

    always_ff @(posedge clk) begin
        if (e.valid && e.regWrite && !hold) begin
            result   <= aluOut;
            writeReg <= e.wr;
        end
    end

endmodule

/* rtl/hazardCtrl.sv */
`timescale 1ns/1ps

module hazardCtrl #(
    parameter int MUL_CYCLES = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic mispredict,
    input  logic mulStart,
    input  logic timerDone,
    output logic stallE,
    output logic flushE,
    output logic timerStart,
    output logic redirect
);
    localparam logic [1:0] RUN     = 2'd0;
    localparam logic [1:0] MULWAIT = 2'd1;
    localparam logic [1:0] MULLAST = 2'd2;             // stall released, result captured

    logic [1:0] state;
    logic [1:0] stateNext;

    always_comb begin
        stateNext = state;
        case (state)
            RUN: begin
                if (mulStart) begin
                    stateNext = MULWAIT;
                end
            end
            MULWAIT: begin
                if (timerDone) begin
                    stateNext = MULLAST;
                end
            end
            default: stateNext = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RUN;
        end else begin
            state <= stateNext;
        end
    end

    assign timerStart = (state == RUN) && mulStart;
    assign stallE     = timerStart || (state == MULWAIT);
    assign flushE     = (state == RUN) && mispredict;
    assign redirect   = flushE;

    assert property (@(posedge clk) disable iff (rst)
        $rose(stallE) |-> ##[1:MUL_CYCLES] !stallE)
        else $error("stall held longer than MUL_CYCLES");

endmodule

/* rtl/idEx.sv */
`timescale 1ns/1ps

module idEx
    import pipePkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic stallE,
    input  logic flushE,
    idExBus.snk  d,
    idExBus.src  e
);

    always_ff @(posedge clk) begin
        if (rst || flushE) begin
            e.pc       <= '0;
            e.pcPlus4  <= '0;
            e.rd1      <= '0;
            e.rd2      <= '0;
            e.rs       <= '0;
            e.rt       <= '0;
            e.wr       <= '0;
            e.imm      <= '0;
            e.sa       <= '0;
            e.aluOp    <= ALU_NONE;
            e.brCond   <= BR_NONE;
            e.useImm   <= 1'b0;
            e.regWrite <= 1'b0;
            e.predTake <= 1'b0;
            e.valid    <= 1'b0;
        end else if (!stallE) begin
            e.pc       <= d.pc;
            e.pcPlus4  <= d.pcPlus4;
            e.rd1      <= d.rd1;
            e.rd2      <= d.rd2;
            e.rs       <= d.rs;
            e.rt       <= d.rt;
            e.wr       <= d.wr;
            e.imm      <= d.imm;
            e.sa       <= d.sa;
            e.aluOp    <= d.aluOp;
            e.brCond   <= d.brCond;
            e.useImm   <= d.useImm;
            e.regWrite <= d.regWrite;
            e.predTake <= d.predTake;
            e.valid    <= d.valid;
        end
    end

    // a flush comes from a branch in E and a stall from a MUL in E, never both
    assert property (@(posedge clk) disable iff (rst) !(flushE && stallE))
        else $error("flushE and stallE asserted together");

endmodule

/* rtl/idExBus.sv */
`timescale 1ns/1ps

interface idExBus
    import pipePkg::*;
();
    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] pcPlus4;
    logic [DATA_W-1:0] rd1;
    logic [DATA_W-1:0] rd2;
    logic [REG_W-1:0]  rs;
    logic [REG_W-1:0]  rt;
    logic [REG_W-1:0]  wr;                            // destination register
    logic [DATA_W-1:0] imm;                           // already sign or zero extended
    logic [REG_W-1:0]  sa;
    aluOpT             aluOp;
    brCondT            brCond;
    logic              useImm;
    logic              regWrite;
    logic              predTake;
    logic              valid;

    modport src (
        output pc, pcPlus4, rd1, rd2, rs, rt, wr, imm, sa,
        output aluOp, brCond, useImm, regWrite, predTake, valid
    );

    modport snk (
        input pc, pcPlus4, rd1, rd2, rs, rt, wr, imm, sa,
        input aluOp, brCond, useImm, regWrite, predTake, valid
    );

endinterface

/* rtl/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode
    import pipePkg::*;
(
    input  logic              instrValid,
    input  logic [DATA_W-1:0] instr,
    input  logic [DATA_W-1:0] pc,
    input  logic [DATA_W-1:0] rd1,
    input  logic [DATA_W-1:0] rd2,
    input  logic              predTake,
    idExBus.src               bus
);
    instrWordT         iw;
    logic [DATA_W-1:0] immSx;
    logic [DATA_W-1:0] immZx;

    assign iw    = instr;
    assign immSx = {{(DATA_W-16){iw.i.imm16[15]}}, iw.i.imm16};
    assign immZx = {{(DATA_W-16){1'b0}}, iw.i.imm16};

    assign bus.pc       = pc;
    assign bus.pcPlus4  = pc + DATA_W'(4);
    assign bus.rd1      = rd1;
    assign bus.rd2      = rd2;
    assign bus.valid    = instrValid;
    assign bus.predTake = instrValid && predTake && (bus.brCond != BR_NONE);    // branches only

    always_comb begin
        bus.rs       = iw.i.rs;
        bus.rt       = iw.i.rt;
        bus.wr       = '0;
        bus.imm      = '0;
        bus.sa       = '0;
        bus.aluOp    = ALU_NONE;
        bus.brCond   = BR_NONE;
        bus.useImm   = 1'b0;
        bus.regWrite = 1'b0;
        case (iw.r.opcode)
            OP_SPECIAL: begin
                bus.wr = iw.r.rd;
                bus.sa = iw.r.sa;
                case (iw.r.funct)
                    FN_ADDU: bus.aluOp = ALU_ADDU;
                    FN_SUBU: bus.aluOp = ALU_SUBU;
                    FN_AND:  bus.aluOp = ALU_AND;
                    FN_OR:   bus.aluOp = ALU_OR;
                    FN_XOR:  bus.aluOp = ALU_XOR;
                    FN_SLT:  bus.aluOp = ALU_SLT;
                    FN_SLL:  bus.aluOp = ALU_SLL;
                    default: bus.aluOp = ALU_NONE;
                endcase
                bus.regWrite = (bus.aluOp != ALU_NONE);
            end
            OP_SPECIAL2: begin
                bus.wr       = iw.r.rd;
                bus.aluOp    = (iw.r.funct == FN_MUL) ? ALU_MUL : ALU_NONE;
                bus.regWrite = (iw.r.funct == FN_MUL);
            end
            OP_ADDIU, OP_ORI, OP_LUI: begin
                bus.wr       = iw.i.rt;                 // I-type writes rt
                bus.useImm   = 1'b1;
                bus.regWrite = 1'b1;
                bus.imm      = (iw.i.opcode == OP_ADDIU) ? immSx : immZx;
                bus.aluOp    = (iw.i.opcode == OP_ADDIU) ? ALU_ADDU :
                               (iw.i.opcode == OP_ORI)   ? ALU_OR   : ALU_LUI;
            end
            OP_BEQ, OP_BNE: begin
                bus.imm    = immSx;
                bus.brCond = (iw.i.opcode == OP_BEQ) ? BR_EQ : BR_NE;
            end
            default: ;                                  // anything else retires as a no-op
        endcase
    end

endmodule

/* rtl/mulTimer.sv */
`timescale 1ns/1ps

module mulTimer #(
    parameter int MUL_CYCLES = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic busy,
    output logic done
);
    localparam int CNT_W = $clog2(MUL_CYCLES);

    logic [CNT_W-1:0] count;

    // the start cycle itself is the first of the MUL_CYCLES
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_W'(MUL_CYCLES - 1);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);
    assign done = (count == CNT_W'(1));                 // last stalled cycle

    assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("multiply timer restarted while busy");

endmodule

/* rtl/pipePkg.sv */
package pipePkg;

    localparam int DATA_W = 32;
    localparam int REG_W  = 5;

    // ************************************************************************
    // opcode and funct encodings of the supported subset
    // ************************************************************************
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;      // home of MUL
    localparam logic [5:0] OP_BEQ      = 6'h04;
    localparam logic [5:0] OP_BNE      = 6'h05;
    localparam logic [5:0] OP_ADDIU    = 6'h09;
    localparam logic [5:0] OP_ORI      = 6'h0d;
    localparam logic [5:0] OP_LUI      = 6'h0f;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_MUL  = 6'h02;           // under OP_SPECIAL2
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // ************************************************************************
    // decoded control and instruction views
    // ************************************************************************
    typedef enum logic [3:0] {
        ALU_NONE = 4'h0,                              // zero so a cleared ID/EX is a no-op
        ALU_ADDU,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI,
        ALU_MUL
    } aluOpT;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ,
        BR_NE
    } brCondT;

    typedef struct packed {
        logic [5:0]       opcode;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] sa;
        logic [5:0]       funct;
    } rFieldsT;

    typedef struct packed {
        logic [5:0]       opcode;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [15:0]      imm16;
    } iFieldsT;

    typedef union packed {
        rFieldsT r;
        iFieldsT i;
    } instrWordT;

endpackage

/* sim.f */
rtl/pipePkg.sv
rtl/idExBus.sv
rtl/instrDecode.sv
rtl/idEx.sv
rtl/execStage.sv
rtl/mulTimer.sv
rtl/hazardCtrl.sv
rtl/exSlice.sv
testbench/exSliceTb.sv

/* testbench/exSliceTb.sv */
`timescale 1ns/1ps

module exSliceTb
    import pipePkg::*;
();
    localparam int     MUL_CYCLES  = 4;                       // the DUT runs at its default
    localparam int     NUM_INSTR   = 400;
    localparam longint WATCHDOG_NS = longint'(NUM_INSTR) * (MUL_CYCLES + 3) * 40 + 2000;

    logic        clk;
    logic        rst;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic        predTake;
    logic        stall;
    logic        redirect;
    logic [31:0] redirectPc;
    logic        resultValid;
    logic [31:0] result;
    logic [4:0]  writeReg;

    integer      seed;
    int          sent;
    logic [31:0] wbValQ[$];
    logic [4:0]  wbRegQ[$];

    // model of the E stage
    logic        eMul;
    logic        eMisp;
    logic [31:0] eTgt;
    int          mulLeft;
    logic        expStall;
    logic        expRedir;
    logic        curStall;
    logic        mWbEn;
    logic [31:0] mWbVal;
    logic [4:0]  mWbReg;
    logic        mIsMul;
    logic        mMisp;
    logic [31:0] mTgt;

    exSlice DUT (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .pc          (pc),
        .rd1         (rd1),
        .rd2         (rd2),
        .predTake    (predTake),
        .stall       (stall),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .resultValid (resultValid),
        .result      (result),
        .writeReg    (writeReg)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // ************************************************************************
    // reference model of one instruction, straight from the ISA rules
    // ************************************************************************
    task automatic modelDecode(
        input  logic [31:0] ins,
        input  logic [31:0] a,
        input  logic [31:0] b,
        input  logic [31:0] pcIn,
        input  logic        pred,
        output logic        wbEn,
        output logic [31:0] wbVal,
        output logic [4:0]  wbReg,
        output logic        isMul,
        output logic        misp,
        output logic [31:0] tgt
    );
        logic [5:0]  op;
        logic [31:0] sx;
        logic        taken;
        op    = ins[31:26];
        sx    = {{16{ins[15]}}, ins[15:0]};
        wbEn  = 1'b1;
        wbVal = '0;
        wbReg = ins[15:11];                                    // rd for R-type
        isMul = 1'b0;
        misp  = 1'b0;
        tgt   = pcIn + 32'd4;
        case (op)
            OP_SPECIAL: begin
                case (ins[5:0])
                    FN_ADDU: wbVal = a + b;
                    FN_SUBU: wbVal = a - b;
                    FN_AND:  wbVal = a & b;
                    FN_OR:   wbVal = a | b;
                    FN_XOR:  wbVal = a ^ b;
                    FN_SLT:  wbVal = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  wbVal = b << ins[10:6];
                    default: wbEn = 1'b0;
                endcase
            end
            OP_SPECIAL2: begin
                isMul = (ins[5:0] == FN_MUL);
                wbEn  = isMul;
                wbVal = a * b;
            end
            OP_ADDIU, OP_ORI, OP_LUI: begin
                wbReg = ins[20:16];
                wbVal = (op == OP_ADDIU) ? a + sx :
                        (op == OP_ORI)   ? a | {16'h0000, ins[15:0]} : {ins[15:0], 16'h0000};
            end
            OP_BEQ, OP_BNE: begin
                wbEn  = 1'b0;
                taken = (op == OP_BEQ) ? (a == b) : (a != b);
                if (taken) begin
                    tgt = pcIn + 32'd4 + (sx << 2);
                end
                misp = (taken != pred);
            end
            default: wbEn = 1'b0;
        endcase
    endtask

    task automatic driveRandomInstr();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] word;
        int          sel;
        a   = $random(seed);
        b   = $random(seed);
        r   = $random(seed);
        sel = {$random(seed)} % 15;
        case (sel)
            0:  word = {OP_SPECIAL, r[4:0], r[9:5], r[14:10], 5'd0, FN_ADDU};
            1:  word = {OP_SPECIAL, r[4:0], r[9:5], r[14:10], 5'd0, FN_SUBU};
            2:  word = {OP_SPECIAL, r[4:0], r[9:5], r[14:10], 5'd0, FN_AND};
            3:  word = {OP_SPECIAL, r[4:0], r[9:5], r[14:10], 5'd0, FN_OR};
            4:  word = {OP_SPECIAL, r[4:0], r[9:5], r[14:10], 5'd0, FN_XOR};
            5:  word = {OP_SPECIAL, r[4:0], r[9:5], r[14:10], 5'd0, FN_SLT};
            6:  word = {OP_SPECIAL, 5'd0, r[9:5], r[14:10], r[19:15], FN_SLL};
            7:  word = {OP_SPECIAL2, r[4:0], r[9:5], r[14:10], 5'd0, FN_MUL};
            8:  word = {OP_ADDIU, r[4:0], r[9:5], r[31:16]};
            9:  word = {OP_ORI, r[4:0], r[9:5], r[31:16]};
            10: word = {OP_LUI, 5'd0, r[9:5], r[31:16]};
            11: word = {OP_BEQ, r[4:0], r[9:5], r[31:16]};
            12: word = {OP_BNE, r[4:0], r[9:5], r[31:16]};
            13: word = {6'h23, r[4:0], r[9:5], r[31:16]};      // a load, outside the subset
            default: word = {OP_SPECIAL, r[4:0], 10'd0, 5'd0, 6'h08};
        endcase
        if ((sel == 11 || sel == 12) && r[15]) begin
            b = a;                                             // make equal operands common
        end
        instrValid <= ({$random(seed)} % 5) != 0;
        instr      <= word;
        pc         <= {r[29:20], a[21:2], 2'b00};
        rd1        <= a;
        rd2        <= b;
        predTake   <= r[30];
    endtask

    // ************************************************************************
    // checks and model update, between the rising edges
    // ************************************************************************
    always @(negedge clk) begin
        if (rst) begin
            eMul     = 1'b0;
            eMisp    = 1'b0;
            eTgt     = '0;
            mulLeft  = 0;
            curStall = 1'b0;
        end else begin
            expStall = eMul && (mulLeft != 0);
            expRedir = eMisp;
            checkEq("stall", stall, expStall);
            checkEq("redirect", redirect, expRedir);
            if (expRedir) begin
                checkEq("redirectPc", redirectPc, eTgt);
            end
            if (resultValid) begin
                if (wbValQ.size() == 0) begin
                    failRun("a write-back appeared while none was expected");
                end else begin
                    checkEq("result", result, wbValQ.pop_front());
                    checkEq("writeReg", writeReg, wbRegQ.pop_front());
                end
            end
            modelDecode(instr, rd1, rd2, pc, predTake, mWbEn, mWbVal, mWbReg, mIsMul,
                        mMisp, mTgt);
            if (expRedir) begin
                eMul  = 1'b0;                                  // flush drops the new one
                eMisp = 1'b0;
            end else if (expStall) begin
                mulLeft = mulLeft - 1;
            end else begin
                if (instrValid && mWbEn) begin
                    wbValQ.push_back(mWbVal);
                    wbRegQ.push_back(mWbReg);
                end
                eMul    = instrValid && mIsMul;
                eMisp   = instrValid && mMisp;
                eTgt    = mTgt;
                mulLeft = eMul ? MUL_CYCLES : 0;
            end
            curStall = expStall;
        end
    end

    initial begin
        seed       = 32'h279b_b2d5;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        rd1        = '0;
        rd2        = '0;
        predTake   = 1'b0;
        sent       = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        while (sent < NUM_INSTR) begin
            @(posedge clk);
            if (!curStall) begin                               // hold inputs during a stall
                driveRandomInstr();
                sent = sent + 1;
            end
        end
        do begin
            @(posedge clk);
        end while (curStall);
        instrValid <= 1'b0;
        repeat (MUL_CYCLES + 3) @(negedge clk);                // a last MUL needs MUL_CYCLES + 2
        if (wbValQ.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            failRun("expected write-backs were still pending at the end");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        failRun("timeout, the expected write-backs never arrived");
    end

endmodule
